//--- files.f
common/riscv_isa_pkg.sv
src/r5p_dec.sv
alu/r5p_alu.sv
src/r5p_bru.sv
src/r5p_wbu.sv
src/r5p_exe.sv
test/r5p_exe_tb.sv

//--- run.sh
#!/bin/sh
# one build and run per logical operand mux option
set -e
for lom in 0 1; do
  verilator --binary --timing -GCFG_LOM=$lom --top-module r5p_exe_tb \
    --Mdir build_lom$lom -f files.f
  out=$(./build_lom$lom/Vr5p_exe_tb)
  echo "$out"
  echo "$out" | grep -q "^TEST PASSED$"
done

//--- test/r5p_exe_tb.sv
module r5p_exe_tb import riscv_isa_pkg::*; #(
  parameter bit CFG_LOM = 1'b0  // overridden per build
);

  // instruction count per test in test order
  localparam int N_INSN    = 1 + 70 + 60 + 10 + 6 + 32;
  localparam int CYC_LIMIT = 2 * N_INSN + 20;

  localparam logic [3:0] R_OPS [7] = '{4'b0000, 4'b1000, 4'b0010, 4'b0011,
                                       4'b0111, 4'b0110, 4'b0100};  // {alt, funct3}
  localparam logic [2:0] I_OPS [6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
  localparam logic [2:0] BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  localparam xlen_t      BR_A  [3] = '{32'h8000_0000, 32'h0000_0001, 32'h5a5a_0005};
  localparam xlen_t      BR_B  [3] = '{32'h0000_0001, 32'h8000_0000, 32'h5a5a_0005};

  logic      clk;
  logic      rst_n;
  logic      insn_vld;
  insn_t     insn;
  xlen_t     pc;
  logic      ret_vld;
  reg_addr_t ret_rd;
  xlen_t     ret_val;
  xlen_t     ret_npc;
  logic      ret_ill;

  xlen_t       model [0:31];  // reference register file
  xlen_t       cur_pc;        // program flow follows expected npc
  logic [31:0] seed = 32'h6235660e;
  int          last_waits;    // extra cycles before last retire
  int          errors;
  int          checks;
  int          tests;
  int          fails;
  int          cyc;

  r5p_exe #(
    .CFG_LOM (CFG_LOM)
  ) UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .insn_vld (insn_vld),
    .insn     (insn),
    .pc       (pc),
    .ret_vld  (ret_vld),
    .ret_rd   (ret_rd),
    .ret_val  (ret_val),
    .ret_npc  (ret_npc),
    .ret_ill  (ret_ill)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cyc = 0;
    while (cyc < CYC_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout, no end of run after %0d cycles", cyc);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;  // lcg step
    return seed;
  endfunction

  function automatic insn_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic insn_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic insn_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OPC_AUIPC};
  endfunction

  function automatic insn_t enc_j(input xlen_t off, input reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic insn_t enc_b(input xlen_t off, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  // rv32i arithmetic rules
  function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return xlen_t'($signed(a) < $signed(b));
      3'b011:  return xlen_t'(a < b);
      3'b100:  return a ^ b;
      3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic br_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report(input string name, input int e0);
    tests++;
    if (errors == e0) begin
      $display("%-8s ok", name);
    end else begin
      fails++;
      $display("%-8s %0d errors", name, errors - e0);
    end
  endtask

  ////////////////////////////////////////
  // instruction drivers
  ////////////////////////////////////////

  // called 1 unit after a rising edge, returns 1 unit after the retire edge
  task automatic exec(input insn_t i, input logic wr, input xlen_t val,
                      input xlen_t npc_exp, input logic ill_exp);
    reg_addr_t rd;
    xlen_t     val_exp;
    int        waits;
    rd       = i[11:7];
    val_exp  = (wr && rd != 5'd0) ? val : '0;  // x0 and no-write retire 0
    insn_vld = 1'b1;
    insn     = i;
    pc       = cur_pc;
    @(posedge clk);
    #1;
    insn_vld = 1'b0;
    waits    = 0;
    while (!ret_vld) begin
      @(posedge clk);
      #1;
      waits++;
    end
    last_waits = waits;
    check_rd("ret_rd", ret_rd, rd);
    check_val("ret_val", ret_val, val_exp);
    check_val("ret_npc", ret_npc, npc_exp);
    check_bit("ret_ill", ret_ill, ill_exp);
    if (wr && rd != 5'd0) model[rd] = val;
    cur_pc = npc_exp;
  endtask

  task automatic op_r(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                      input reg_addr_t rs1, input reg_addr_t rs2);
    exec(enc_r(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd), 1'b1,
         alu_ref(f3, alt, model[rs1], model[rs2]), cur_pc + 4, 1'b0);
  endtask

  // shift immediates carry funct7 in imm[11:5]
  task automatic op_i(input logic [2:0] f3, input logic [11:0] imm, input reg_addr_t rd,
                      input reg_addr_t rs1);
    exec(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), 1'b1,
         alu_ref(f3, (f3 == 3'b101) && imm[10], model[rs1], {{20{imm[11]}}, imm}),
         cur_pc + 4, 1'b0);
  endtask

  // pc relative auipc then addi
  task automatic load_reg(input reg_addr_t rd, input xlen_t v);
    xlen_t d;
    xlen_t hi;
    d  = v - cur_pc;
    hi = d + 32'h800;  // offsets addi sign extension
    exec(enc_u(hi[31:12], rd), 1'b1, cur_pc + {hi[31:12], 12'b0}, cur_pc + 4, 1'b0);
    op_i(3'b000, d[11:0], rd, rd);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset();
    int e;
    e = errors;
    check_bit("ret_vld", ret_vld, 1'b0);
    op_i(3'b000, 12'h000, 5'd5, 5'd1);  // x1 still 0
    report("reset", e);
  endtask

  task automatic test_arith();
    int          e;
    logic [31:0] r;
    e = errors;
    op_i(3'b000, 12'h07b, 5'd0, 5'd0);     // write to x0 dropped
    op_r(3'b000, 1'b0, 5'd6, 5'd0, 5'd0);  // x0 + x0
    for (int n = 0; n < 4; n++) begin
      load_reg(5'd1, rand_word());
      load_reg(5'd2, rand_word());
      foreach (R_OPS[k]) op_r(R_OPS[k][2:0], R_OPS[k][3], 5'd3, 5'd1, 5'd2);
      foreach (I_OPS[k]) begin
        r = rand_word();
        op_i(I_OPS[k], r[11:0], 5'd4, 5'd1);
      end
    end
    report("arith", e);
  endtask

  task automatic test_shift();
    int          e;
    logic [31:0] v;
    logic [31:0] r;
    logic [4:0]  amts [4];
    e = errors;
    for (int s = 0; s < 2; s++) begin
      v     = rand_word();
      v[31] = (s == 0);  // negative operand first
      load_reg(5'd1, v);
      r       = rand_word();
      amts[0] = 5'd0;
      amts[1] = 5'd31;
      amts[2] = r[4:0];
      amts[3] = r[9:5];
      foreach (amts[k]) begin
        op_i(3'b000, {r[16:10], amts[k]}, 5'd2, 5'd0);  // junk above amount
        op_r(3'b001, 1'b0, 5'd3, 5'd1, 5'd2);
        op_r(3'b101, 1'b0, 5'd3, 5'd1, 5'd2);
        op_r(3'b101, 1'b1, 5'd3, 5'd1, 5'd2);
        op_i(3'b001, {7'b0000000, amts[k]}, 5'd4, 5'd1);
        op_i(3'b101, {7'b0000000, amts[k]}, 5'd4, 5'd1);
        op_i(3'b101, {7'b0100000, amts[k]}, 5'd4, 5'd1);
      end
    end
    report("shift", e);
  endtask

  task automatic test_chain();
    int          e;
    logic [31:0] r;
    e = errors;
    load_reg(5'd7, rand_word());
    @(posedge clk);  // one idle cycle
    #1;
    check_bit("ret_vld", ret_vld, 1'b0);  // no retire without instruction
    for (int n = 0; n < 8; n++) begin
      r = rand_word();
      if (n[0]) op_r(3'b000, 1'b0, 5'd7, 5'd7, 5'd7);  // doubles x7
      else      op_i(3'b100, r[11:0], 5'd7, 5'd7);
      checks++;
      if (last_waits != 0) begin
        errors++;
        $display("retire came %0d cycles late at time %0t", last_waits, $time);
      end
    end
    report("chain", e);
  endtask

  task automatic test_jump();
    int e;
    e = errors;
    cur_pc = 32'h0000_2000;
    exec(enc_u(20'h12345, 5'd8), 1'b1, cur_pc + 32'h1234_5000, cur_pc + 4, 1'b0);
    exec(enc_j(32'h0000_0a40, 5'd9), 1'b1, cur_pc + 4, cur_pc + 32'h0000_0a40, 1'b0);
    exec(enc_j(32'hffff_f3c8, 5'd10), 1'b1, cur_pc + 4, cur_pc + 32'hffff_f3c8, 1'b0);
    load_reg(5'd11, 32'h0000_5a31);  // odd base and odd target
    exec(enc_i(12'h7f2, 5'd11, 3'b000, 5'd12, OPC_JALR), 1'b1, cur_pc + 4,
         (model[11] + 32'h0000_07f2) & ~32'h1, 1'b0);
    report("jump", e);
  endtask

  task automatic test_branch();
    int    e;
    xlen_t off;
    e = errors;
    foreach (BR_A[p]) begin
      load_reg(5'd1, BR_A[p]);
      load_reg(5'd2, BR_B[p]);
      foreach (BR_F3[k]) begin
        off = k[0] ? 32'hffff_ffe0 : 32'h0000_0124;  // back and forward
        exec(enc_b(off, 5'd2, 5'd1, BR_F3[k]), 1'b0, '0,
             br_ref(BR_F3[k], model[1], model[2]) ? cur_pc + off : cur_pc + 4, 1'b0);
      end
    end
    // load opcode is not supported
    exec(enc_i(12'h010, 5'd2, 3'b010, 5'd1, 7'b0000011), 1'b0, '0, cur_pc + 4, 1'b1);
    op_i(3'b000, 12'h000, 5'd14, 5'd1);  // x1 untouched
    report("branch", e);
  endtask

  ////////////////////////////////////////
  // main
  ////////////////////////////////////////

  initial begin
    rst_n    = 1'b0;
    insn_vld = 1'b1;  // addi to x1 during reset is dropped
    insn     = enc_i(12'h123, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);
    pc       = '0;
    cur_pc   = 32'h0000_1000;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    fails    = 0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    insn_vld = 1'b0;
    test_reset();
    test_arith();
    test_shift();
    test_chain();
    test_jump();
    test_branch();
    $display("CFG_LOM=%0d: %0d tests, %0d failed, %0d checks, %0d errors",
             CFG_LOM, tests, fails, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- src/r5p_exe.sv
module r5p_exe import riscv_isa_pkg::*; #(
  bit CFG_LOM = 1'b0  // passed to ALU
)(
  input  logic      clk,
  input  logic      rst_n,
  // instruction in
  input  logic      insn_vld,
  input  insn_t     insn,
  input  xlen_t     pc,
  // retire out
  output logic      ret_vld,
  output reg_addr_t ret_rd,
  output xlen_t     ret_val,
  output xlen_t     ret_npc,
  output logic      ret_ill
);

  // decoder outputs
  alu_op_t      alu_op;
  alu_in_t      alu_in;
  result_sign_t sgn;
  ctl_kind_t    kind;
  funct3_t      funct3;
  reg_addr_t    rs1_addr;
  reg_addr_t    rs2_addr;
  reg_addr_t    rd_addr;
  xlen_t        imm_i;
  xlen_t        imm_u;
  xlen_t        imm_j;
  xlen_t        imm_b;
  // datapath
  xlen_t        rs1_val;
  xlen_t        rs2_val;
  xlen_t        rd_val;
  xsum_t        sum;
  // branch unit
  xlen_t        npc;
  logic         link_sel;
  xlen_t        link;
  logic         wr_en;

  r5p_dec dec (
    .insn     (insn),
    .alu_op   (alu_op),
    .alu_in   (alu_in),
    .sgn      (sgn),
    .kind     (kind),
    .funct3   (funct3),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .imm_i    (imm_i),
    .imm_u    (imm_u),
    .imm_j    (imm_j),
    .imm_b    (imm_b)
  );

  r5p_wbu wbu (
    .clk      (clk),
    .rst_n    (rst_n),
    .insn_vld (insn_vld),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .link_sel (link_sel),
    .link     (link),
    .alu_val  (rd_val),
    .npc      (npc),
    .ill      (kind == K_ILL),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .ret_vld  (ret_vld),
    .ret_rd   (ret_rd),
    .ret_val  (ret_val),
    .ret_npc  (ret_npc),
    .ret_ill  (ret_ill)
  );

  r5p_alu #(
    .CFG_LOM (CFG_LOM)
  ) alu (
    .alu_op (alu_op),
    .alu_in (alu_in),
    .sgn    (sgn),
    .pc     (pc),
    .rs1    (rs1_val),
    .rs2    (rs2_val),
    .imm_i  (imm_i),
    .imm_u  (imm_u),
    .imm_j  (imm_j),
    .imm_b  (imm_b),
    .rd     (rd_val),
    .sum    (sum)
  );

  r5p_bru bru (
    .kind     (kind),
    .funct3   (funct3),
    .pc       (pc),
    .imm_b    (imm_b),
    .sum      (sum),
    .npc      (npc),
    .link_sel (link_sel),
    .link     (link),
    .wr_en    (wr_en)
  );

endmodule

//--- src/r5p_wbu.sv
module r5p_wbu import riscv_isa_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      insn_vld,
  // register indices
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  // write back control and data
  input  logic      wr_en,
  input  logic      link_sel,
  input  xlen_t     link,
  input  xlen_t     alu_val,
  input  xlen_t     npc,
  input  logic      ill,
  // read ports
  output xlen_t     rs1_val,
  output xlen_t     rs2_val,
  // retire record
  output logic      ret_vld,
  output reg_addr_t ret_rd,
  output xlen_t     ret_val,
  output xlen_t     ret_npc,
  output logic      ret_ill
);

  xlen_t gpr [1:31];  // x0 is not stored
  xlen_t wr_val;
  logic  wr_act;

  assign wr_val = link_sel ? link : alu_val;
  assign wr_act = insn_vld && wr_en && (rd_addr != '0);

  // x0 reads zero
  assign rs1_val = (rs1_addr == '0) ? '0 : gpr[rs1_addr];
  assign rs2_val = (rs2_addr == '0) ? '0 : gpr[rs2_addr];

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (wr_act) begin
      gpr[rd_addr] <= wr_val;  // visible to next instruction
    end
  end

  ////////////////////////////////////////
  // retire
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) ret_vld <= 1'b0;
    else        ret_vld <= insn_vld;
  end

  always_ff @(posedge clk) begin
    if (insn_vld) begin
      ret_rd  <= rd_addr;
      ret_val <= wr_act ? wr_val : '0;  // zero when nothing written
      ret_npc <= npc;
      ret_ill <= ill;
    end
  end

endmodule

//--- src/r5p_bru.sv
module r5p_bru import riscv_isa_pkg::*; (
  input  ctl_kind_t kind,
  input  funct3_t   funct3,
  input  xlen_t     pc,
  input  xlen_t     imm_b,
  input  xsum_t     sum,       // rs1 - rs2 for branches
  output xlen_t     npc,
  output logic      link_sel,  // write link instead of ALU result
  output xlen_t     link,
  output logic      wr_en
);

  logic  eq;
  logic  lt;
  logic  taken;
  xlen_t pc_br;  // branch target

  assign eq    = (sum[XLEN-1:0] == '0);
  assign lt    = sum[XLEN];  // borrow or sign bit
  assign link  = pc + xlen_t'(4);
  assign pc_br = pc + imm_b;

  always_comb begin
    case (funct3)
      F3_BEQ:  taken =  eq;
      F3_BNE:  taken = ~eq;
      F3_BLT,
      F3_BLTU: taken =  lt;
      F3_BGE,
      F3_BGEU: taken = ~lt;
      default: taken = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // next pc and write back select
  ////////////////////////////////////////

  always_comb begin
    npc      = link;  // sequential by default
    link_sel = 1'b0;
    wr_en    = 1'b0;
    case (kind)
      K_ALU, K_AUIPC: wr_en = 1'b1;
      K_JAL: begin
        npc      = sum[XLEN-1:0];
        link_sel = 1'b1;
        wr_en    = 1'b1;
      end
      K_JALR: begin
        npc      = {sum[XLEN-1:1], 1'b0};  // clear bit 0
        link_sel = 1'b1;
        wr_en    = 1'b1;
      end
      K_BRANCH: npc = taken ? pc_br : link;
      default: ;  // illegal, no write
    endcase
  end

endmodule

//--- alu/r5p_alu.sv
module r5p_alu import riscv_isa_pkg::*; #(
  bit CFG_LOM = 1'b0  // dedicated logical operand mux
)(
  // control from decoder
  input  alu_op_t      alu_op,
  input  alu_in_t      alu_in,
  input  result_sign_t sgn,
  // data
  input  xlen_t        pc,
  input  xlen_t        rs1,
  input  xlen_t        rs2,
  input  xlen_t        imm_i,
  input  xlen_t        imm_u,
  input  xlen_t        imm_j,
  input  xlen_t        imm_b,
  output xlen_t        rd,
  output xsum_t        sum   // side output for branch unit
);

  localparam int unsigned XLOG = $clog2(XLEN);

  xsum_t           add_op1;  // extended by one bit
  xsum_t           add_op2;
  logic            add_inv;  // subtract
  xlen_t           log_op1;
  xlen_t           log_op2;
  logic [XLOG-1:0] shf_sam;  // shift amount
  xlen_t           shf_tmp;  // operand, reversed for sll
  xlen_t           shf_val;

  function automatic xsum_t extend(xlen_t val, result_sign_t s);
    if (s == R_U) extend = {1'b0, val};
    else          extend = {val[XLEN-1], val};
  endfunction

  ////////////////////////////////////////
  // adder
  ////////////////////////////////////////

  always_comb begin
    case (alu_in)
      AI_R1_R2: begin add_op1 = extend(rs1, sgn); add_op2 = extend(rs2,   sgn); end
      AI_R1_II: begin add_op1 = extend(rs1, sgn); add_op2 = extend(imm_i, sgn); end
      AI_PC_IU: begin add_op1 = extend(pc,  R_S); add_op2 = extend(imm_u, R_S); end
      AI_PC_IJ: begin add_op1 = extend(pc,  R_S); add_op2 = extend(imm_j, R_S); end
      AI_PC_IB: begin add_op1 = extend(pc,  R_S); add_op2 = extend(imm_b, R_S); end
      AI_R1_RA: begin add_op1 = extend(rs1, sgn); add_op2 = extend(rs2,   sgn); end
      default:  begin add_op1 = '0;               add_op2 = '0;               end
    endcase
  end

  // invert operand 2 for subtract and compares
  always_comb begin
    case (alu_op)
      AO_SUB, AO_SLT, AO_SLTU: add_inv = 1'b1;
      default:                 add_inv = 1'b0;
    endcase
  end

  assign sum = add_op1 + (add_inv ? ~add_op2 : add_op2) + xsum_t'(add_inv);

  ////////////////////////////////////////
  // logical operands
  ////////////////////////////////////////

  generate
    if (CFG_LOM) begin : gen_lom_ena
      always_comb begin
        case (alu_in)
          AI_R1_R2: begin log_op1 = rs1; log_op2 = rs2;   end
          AI_R1_II: begin log_op1 = rs1; log_op2 = imm_i; end
          default:  begin log_op1 = '0;  log_op2 = '0;    end
        endcase
      end
    end else begin : gen_lom_alu
      assign log_op1 = add_op1[XLEN-1:0];  // shared with adder mux
      assign log_op2 = add_op2[XLEN-1:0];
    end
  endgenerate

  ////////////////////////////////////////
  // barrel shifter
  ////////////////////////////////////////

  assign shf_sam = (alu_in == AI_R1_RA) ? rs2[XLOG-1:0] : imm_i[XLOG-1:0];

  // left shift done as reverse, shift right, reverse
  assign shf_tmp = (alu_op == AO_SLL) ? {<<{rs1}} : rs1;

  always_comb begin
    if (alu_op == AO_SRA) shf_val = $signed(shf_tmp) >>> shf_sam;  // sign fill
    else                  shf_val = shf_tmp >> shf_sam;
  end

  ////////////////////////////////////////
  // result mux
  ////////////////////////////////////////

  always_comb begin
    case (alu_op)
      AO_ADD,
      AO_SUB:  rd = sum[XLEN-1:0];
      AO_SLT,
      AO_SLTU: rd = xlen_t'(sum[XLEN]);  // sign of extended difference
      AO_AND:  rd = log_op1 & log_op2;
      AO_OR:   rd = log_op1 | log_op2;
      AO_XOR:  rd = log_op1 ^ log_op2;
      AO_SRA,
      AO_SRL:  rd = shf_val;
      AO_SLL:  rd = {<<{shf_val}};  // undo reversal
      default: rd = '0;
    endcase
  end

endmodule

//--- src/r5p_dec.sv
module r5p_dec import riscv_isa_pkg::*; (
  input  insn_t        insn,
  // control record
  output alu_op_t      alu_op,
  output alu_in_t      alu_in,
  output result_sign_t sgn,
  output ctl_kind_t    kind,
  output funct3_t      funct3,
  // register indices
  output reg_addr_t    rs1_addr,
  output reg_addr_t    rs2_addr,
  output reg_addr_t    rd_addr,
  // immediates, sign extended
  output xlen_t        imm_i,
  output xlen_t        imm_u,
  output xlen_t        imm_j,
  output xlen_t        imm_b
);

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra

  opcode_t    opcode;
  logic [6:0] funct7;

  assign opcode   = insn[6:0];
  assign funct3   = insn[14:12];
  assign funct7   = insn[31:25];
  assign rd_addr  = insn[11:7];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

  ////////////////////////////////////////
  // control decode
  ////////////////////////////////////////

  always_comb begin
    alu_op = AO_ILL;  // illegal unless matched below
    alu_in = AI_R1_R2;
    kind   = K_ILL;
    case (opcode)
      OPC_OP: begin
        // shifts take the amount from rs2
        alu_in = (funct3 == 3'b001 || funct3 == 3'b101) ? AI_R1_RA : AI_R1_R2;
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: alu_op = AO_ADD;
          {F7_ALT , 3'b000}: alu_op = AO_SUB;
          {F7_BASE, 3'b001}: alu_op = AO_SLL;
          {F7_BASE, 3'b010}: alu_op = AO_SLT;
          {F7_BASE, 3'b011}: alu_op = AO_SLTU;
          {F7_BASE, 3'b100}: alu_op = AO_XOR;
          {F7_BASE, 3'b101}: alu_op = AO_SRL;
          {F7_ALT , 3'b101}: alu_op = AO_SRA;
          {F7_BASE, 3'b110}: alu_op = AO_OR;
          {F7_BASE, 3'b111}: alu_op = AO_AND;
          default:           alu_op = AO_ILL;
        endcase
        kind = (alu_op == AO_ILL) ? K_ILL : K_ALU;
      end
      OPC_OP_IMM: begin
        alu_in = AI_R1_II;
        case (funct3)
          3'b000: alu_op = AO_ADD;
          3'b010: alu_op = AO_SLT;
          3'b011: alu_op = AO_SLTU;
          3'b100: alu_op = AO_XOR;
          3'b110: alu_op = AO_OR;
          3'b111: alu_op = AO_AND;
          3'b001: alu_op = (funct7 == F7_BASE) ? AO_SLL : AO_ILL;  // shamt[5] must be 0
          3'b101: alu_op = (funct7 == F7_BASE) ? AO_SRL :
                           (funct7 == F7_ALT ) ? AO_SRA : AO_ILL;
          default: alu_op = AO_ILL;
        endcase
        kind = (alu_op == AO_ILL) ? K_ILL : K_ALU;
      end
      OPC_AUIPC: begin
        alu_op = AO_ADD;
        alu_in = AI_PC_IU;
        kind   = K_AUIPC;
      end
      OPC_JAL: begin
        alu_op = AO_ADD;  // target pc + imm_j
        alu_in = AI_PC_IJ;
        kind   = K_JAL;
      end
      OPC_JALR: begin
        alu_op = (funct3 == 3'b000) ? AO_ADD : AO_ILL;
        alu_in = AI_R1_II;  // target rs1 + imm_i
        kind   = (funct3 == 3'b000) ? K_JALR : K_ILL;
      end
      OPC_BRANCH: begin
        case (funct3)
          F3_BEQ, F3_BNE, F3_BLT, F3_BGE: alu_op = AO_SUB;  // signed compare
          F3_BLTU, F3_BGEU:               alu_op = AO_SLTU; // unsigned compare
          default:                        alu_op = AO_ILL;
        endcase
        kind = (alu_op == AO_ILL) ? K_ILL : K_BRANCH;
      end
      default: ;  // unsupported opcode stays illegal
    endcase
    // zero extension only for sltu and unsigned branches
    sgn = (alu_op == AO_SLTU) ? R_U : R_S;
  end

endmodule

//--- common/riscv_isa_pkg.sv
package riscv_isa_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int unsigned XLEN = 32;  // RV32 only

  typedef logic [XLEN-1:0] xlen_t;    // data word or PC
  typedef logic [XLEN-0:0] xsum_t;    // adder result with carry/sign bit
  typedef logic [32-1:0]   insn_t;    // instruction word
  typedef logic [5-1:0]    reg_addr_t;
  typedef logic [7-1:0]    opcode_t;
  typedef logic [3-1:0]    funct3_t;

  ////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////

  localparam opcode_t OPC_OP     = 7'b0110011;  // register arithmetic
  localparam opcode_t OPC_OP_IMM = 7'b0010011;  // immediate arithmetic
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // branch conditions in funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  ////////////////////////////////////////
  // control encodings
  ////////////////////////////////////////

  // ALU operation
  typedef enum logic [3:0] {
    AO_ADD,
    AO_SUB,
    AO_SLT,
    AO_SLTU,
    AO_AND,
    AO_OR,
    AO_XOR,
    AO_SRA,
    AO_SRL,
    AO_SLL,
    AO_ILL   // no valid operation
  } alu_op_t;

  // adder operand pair
  typedef enum logic [2:0] {
    AI_R1_R2,  // R-type
    AI_R1_II,  // I-type arithmetic/logic, JALR
    AI_PC_IU,  // U-type
    AI_PC_IJ,  // J-type
    AI_PC_IB,  // B-type
    AI_R1_RA   // rs2 is shift amount
  } alu_in_t;

  // operand extension
  typedef enum logic {
    R_S,  // signed
    R_U   // unsigned
  } result_sign_t;

  // instruction class
  typedef enum logic [2:0] {
    K_ALU,
    K_AUIPC,
    K_JAL,
    K_JALR,
    K_BRANCH,
    K_ILL
  } ctl_kind_t;

endpackage
